//--- dma_regs_pkg.sv
`default_nettype none

package dma_regs_pkg;

	// ******************************
	// Widths
	// ******************************
	localparam int DATA_W = 32;
	localparam int SEL_W = 4;
	localparam int REG_IDX_W = 10;
	localparam int BUS_ADDR_W = 32;
	localparam int FIFO_CNT_W = 28;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

	// FIFO marks and limits
	localparam fifo_cnt_t DMA_FIFO_FULL_MARK = 28'd4083;
	localparam fifo_cnt_t DMA_FIFO_LIMIT = 28'd4084;
	localparam fifo_cnt_t RD_FIFO_LIMIT = 28'd2040;
	localparam fifo_cnt_t RD_FIFO_EMPTY_MARK = 28'd1;

	localparam int NUM_DMA_FIFO = 2;
	localparam int NUM_RD_FIFO = 2;

	// Wishbone cycle type
	typedef enum logic [2:0] {
		CTI_CLASSIC = 3'b000,
		CTI_CONST = 3'b001,
		CTI_INCR = 3'b010,
		CTI_END = 3'b111
	} cti_e;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		SINGLE = 2'd1,
		BURST = 2'd2,
		ERROR = 2'd3
	} wb_state_e;

	// ******************************
	// Register map, word index
	// ******************************
	typedef enum logic [REG_IDX_W-1:0] {
		REG_CONTROL = 10'd1,
		REG_DMA_ADDR = 10'd2,
		REG_DMA_LEN = 10'd3,
		REG_XFER_SIZE = 10'd4,
		REG_STATUS = 10'd5,
		REG_DMA_FIFO0_STAT = 10'd6,
		REG_DMA_FIFO0_CTRL = 10'd7,
		REG_RD_FIFO0_STAT = 10'd8,
		REG_RD_FIFO0_CTRL = 10'd9,
		REG_RD_FIFO1_STAT = 10'd10,
		REG_RD_FIFO1_CTRL = 10'd11,
		REG_DMA_FIFO1_STAT = 10'd16,
		REG_DMA_FIFO1_CTRL = 10'd17
	} reg_addr_e;

	typedef enum logic {
		FIFO_FILL = 1'b0,
		FIFO_DRAIN = 1'b1
	} fifo_kind_e;

	// Selected byte lanes take new data, the rest keep theirs
	function automatic data_t byte_merge(input data_t cur, input data_t wdata, input sel_t be);
		data_t res;
		res = cur;
		for (int i = 0; i < SEL_W; i++) begin
			if (be[i])
				res[8*i +: 8] = wdata[8*i +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

//--- wb_cycle_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module wb_cycle_decoder (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire logic we_i,
	input wire logic [dma_regs_pkg::BUS_ADDR_W-1:0] adr_i,
	input wire dma_regs_pkg::cti_e cti_i,
	input wire dma_regs_pkg::sel_t sel_i,
	input wire dma_regs_pkg::data_t dat_i,
	output logic ack_o,
	output logic err_o,
	output logic wr_en_o,
	output dma_regs_pkg::reg_idx_t reg_idx_o,
	output dma_regs_pkg::data_t wdata_o,
	output dma_regs_pkg::sel_t be_o
);

	import dma_regs_pkg::*;

	wb_state_e state_q;
	wb_state_e state_d;
	logic req;
	logic ack_q;
	logic we_q;
	reg_idx_t idx_q;
	data_t wdata_q;
	sel_t be_q;

	assign req = cyc_i & stb_i;

	// State describes the request sampled at the last edge
	always_comb begin
		state_d = IDLE;
		if (req) begin
			if (state_q == BURST) begin
				case (cti_i)
					CTI_CONST, CTI_INCR: state_d = BURST;
					CTI_END: state_d = SINGLE;
					default: state_d = ERROR;
				endcase
			end else begin
				case (cti_i)
					CTI_CLASSIC, CTI_END: state_d = SINGLE;
					CTI_CONST, CTI_INCR: state_d = BURST;
					default: state_d = ERROR;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= IDLE;
			ack_q <= 1'b0;
		end else begin
			state_q <= state_d;
			ack_q <= req;
		end
	end

	// ******************************
	// Request capture
	// ******************************
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			idx_q <= '1;
			we_q <= 1'b0;
		end else if (req) begin
			idx_q <= adr_i[11:2];
			we_q <= we_i;
		end else begin
			// Park on an unmapped word
			idx_q <= '1;
			we_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (req) begin
			wdata_q <= dat_i;
			be_q <= sel_i;
		end
	end

	assign ack_o = ack_q;
	assign err_o = (state_q == ERROR);
	assign wr_en_o = we_q && (state_q == SINGLE || state_q == BURST);
	assign reg_idx_o = idx_q;
	assign wdata_o = wdata_q;
	assign be_o = be_q;

endmodule

`default_nettype wire

//--- dma_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module dma_ctrl_regs (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic wr_en_i,
	input wire dma_regs_pkg::reg_idx_t reg_idx_i,
	input wire dma_regs_pkg::data_t wdata_i,
	input wire dma_regs_pkg::sel_t be_i,
	input wire logic dma_in_use_i,
	input wire dma_regs_pkg::data_t transfer_size_i,
	input wire logic transfer_size_valid_i,
	input wire logic [7:0] stat_i,
	input wire logic stat_valid_i,
	output dma_regs_pkg::data_t rdata_o,
	output logic [15:0] ctrl_o,
	output logic [15:0] watch_dog_cnt_o,
	output dma_regs_pkg::data_t dmaadr_o,
	output dma_regs_pkg::data_t dmalen_o
);

	import dma_regs_pkg::*;

	data_t control_q;
	data_t dmaadr_q;
	data_t dmalen_q;
	data_t xfer_size_q;
	logic [7:0] stat_q;

	// ******************************
	// Host writable registers
	// ******************************
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			control_q <= '0;
			dmaadr_q <= '0;
			dmalen_q <= '0;
		end else if (wr_en_i) begin
			if (!dma_in_use_i) begin
				case (reg_idx_i)
					REG_CONTROL: control_q <= byte_merge(control_q, wdata_i, be_i);
					REG_DMA_ADDR: dmaadr_q <= byte_merge(dmaadr_q, wdata_i, be_i);
					REG_DMA_LEN: dmalen_q <= byte_merge(dmalen_q, wdata_i, be_i);
					default: ;
				endcase
			end else if (reg_idx_i == REG_CONTROL && be_i[3]) begin
				// Busy: only the top control bit may change
				control_q[31] <= wdata_i[31];
			end
		end
	end

	// ******************************
	// Engine results
	// ******************************
	always_ff @(posedge clk_i) begin
		if (reset_i)
			xfer_size_q <= '0;
		else if (transfer_size_valid_i)
			xfer_size_q <= transfer_size_i;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			stat_q <= '0;
		else if (stat_valid_i)
			stat_q <= stat_i;
	end

	// Read mux
	always_comb begin
		case (reg_idx_i)
			REG_CONTROL: rdata_o = control_q;
			REG_DMA_ADDR: rdata_o = dmaadr_q;
			REG_DMA_LEN: rdata_o = dmalen_q;
			REG_XFER_SIZE: rdata_o = xfer_size_q;
			REG_STATUS: rdata_o = {16'd0, dma_in_use_i, 7'd0, stat_q};
			default: rdata_o = '0;
		endcase
	end

	assign ctrl_o = control_q[31:16];
	assign watch_dog_cnt_o = control_q[15:0];
	assign dmaadr_o = dmaadr_q;
	assign dmalen_o = dmalen_q;

endmodule

`default_nettype wire

//--- fifo_watch.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_watch #(
	parameter dma_regs_pkg::fifo_kind_e KIND = dma_regs_pkg::FIFO_FILL,
	parameter dma_regs_pkg::fifo_cnt_t MARK = dma_regs_pkg::DMA_FIFO_FULL_MARK,
	parameter dma_regs_pkg::fifo_cnt_t LIMIT = dma_regs_pkg::DMA_FIFO_LIMIT,
	parameter dma_regs_pkg::reg_idx_t STATUS_ADDR = dma_regs_pkg::REG_DMA_FIFO0_STAT,
	parameter dma_regs_pkg::reg_idx_t CTRL_ADDR = dma_regs_pkg::REG_DMA_FIFO0_CTRL
) (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic wr_en_i,
	input wire dma_regs_pkg::reg_idx_t reg_idx_i,
	input wire dma_regs_pkg::data_t wdata_i,
	input wire dma_regs_pkg::sel_t be_i,
	input wire dma_regs_pkg::fifo_cnt_t level_i,
	output dma_regs_pkg::data_t rdata_o,
	output logic int_o
);

	import dma_regs_pkg::*;

	data_t ctrl_q;
	data_t status_q;
	data_t status_d;
	fifo_cnt_t slots;
	logic flag;

	// Free entries left in a drain FIFO
	assign slots = LIMIT - level_i;

	always_comb begin
		if (KIND == FIFO_FILL) begin
			flag = (level_i > MARK);
			status_d = {flag, 3'b000, level_i[FIFO_CNT_W-3:0], 2'b00};
		end else begin
			flag = (level_i < MARK);
			if (level_i > LIMIT)
				status_d = {flag, 31'd0};
			else
				status_d = {flag, 3'b000, slots[FIFO_CNT_W-3:0], 2'b00};
		end
	end

	// ******************************
	// Status and control
	// ******************************
	always_ff @(posedge clk_i) begin
		if (reset_i)
			status_q <= '0;
		else
			status_q <= status_d;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			ctrl_q <= '0;
		else if (wr_en_i && reg_idx_i == CTRL_ADDR)
			ctrl_q <= byte_merge(ctrl_q, wdata_i, be_i);
	end

	always_comb begin
		if (reg_idx_i == STATUS_ADDR)
			rdata_o = status_q;
		else if (reg_idx_i == CTRL_ADDR)
			rdata_o = ctrl_q;
		else
			rdata_o = '0;
	end

	// Bit 31 of control enables the interrupt
	assign int_o = status_q[31] & ctrl_q[31];

endmodule

`default_nettype wire

//--- wb_dma_regs_top.sv
`timescale 1ns/1ns
`default_nettype none

module wb_dma_regs_top #(
	parameter dma_regs_pkg::fifo_cnt_t DMA_FULL_MARK = dma_regs_pkg::DMA_FIFO_FULL_MARK,
	parameter dma_regs_pkg::fifo_cnt_t DMA_LIMIT = dma_regs_pkg::DMA_FIFO_LIMIT,
	parameter dma_regs_pkg::fifo_cnt_t RD_LIMIT = dma_regs_pkg::RD_FIFO_LIMIT,
	parameter dma_regs_pkg::fifo_cnt_t RD_EMPTY_MARK = dma_regs_pkg::RD_FIFO_EMPTY_MARK
) (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire logic we_i,
	input wire logic [dma_regs_pkg::BUS_ADDR_W-1:0] adr_i,
	input wire dma_regs_pkg::cti_e cti_i,
	input wire dma_regs_pkg::sel_t sel_i,
	input wire dma_regs_pkg::data_t dat_i,
	output dma_regs_pkg::data_t dat_o,
	output logic ack_o,
	output logic err_o,
	input wire logic dma_in_use_i,
	output logic [15:0] ctrl_o,
	output logic [15:0] watch_dog_cnt_o,
	output dma_regs_pkg::data_t dmaadr_o,
	output dma_regs_pkg::data_t dmalen_o,
	input wire dma_regs_pkg::data_t transfer_size_i,
	input wire logic transfer_size_valid_i,
	input wire logic [7:0] stat_i,
	input wire logic stat_valid_i,
	input wire dma_regs_pkg::fifo_cnt_t dma_fifo_cnt_i [dma_regs_pkg::NUM_DMA_FIFO],
	output logic [dma_regs_pkg::NUM_DMA_FIFO-1:0] dma_fifo_full_int_o,
	input wire dma_regs_pkg::fifo_cnt_t rd_fifo_length_i [dma_regs_pkg::NUM_RD_FIFO],
	output logic [dma_regs_pkg::NUM_RD_FIFO-1:0] rd_fifo_empty_int_o
);

	import dma_regs_pkg::*;

	logic wr_en;
	reg_idx_t reg_idx;
	data_t wdata;
	sel_t be;
	data_t ctrl_rdata;
	data_t dma_rdata [NUM_DMA_FIFO];
	data_t rd_rdata [NUM_RD_FIFO];

	wb_cycle_decoder u_decoder (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.cti_i(cti_i),
		.sel_i(sel_i),
		.dat_i(dat_i),
		.ack_o(ack_o),
		.err_o(err_o),
		.wr_en_o(wr_en),
		.reg_idx_o(reg_idx),
		.wdata_o(wdata),
		.be_o(be)
	);

	dma_ctrl_regs u_ctrl (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.wr_en_i(wr_en),
		.reg_idx_i(reg_idx),
		.wdata_i(wdata),
		.be_i(be),
		.dma_in_use_i(dma_in_use_i),
		.transfer_size_i(transfer_size_i),
		.transfer_size_valid_i(transfer_size_valid_i),
		.stat_i(stat_i),
		.stat_valid_i(stat_valid_i),
		.rdata_o(ctrl_rdata),
		.ctrl_o(ctrl_o),
		.watch_dog_cnt_o(watch_dog_cnt_o),
		.dmaadr_o(dmaadr_o),
		.dmalen_o(dmalen_o)
	);

	// ******************************
	// FIFO watchers
	// ******************************
	for (genvar i = 0; i < NUM_DMA_FIFO; i++) begin : g_dma_fifo
		fifo_watch #(
			.KIND(FIFO_FILL),
			.MARK(DMA_FULL_MARK),
			.LIMIT(DMA_LIMIT),
			.STATUS_ADDR(i == 0 ? REG_DMA_FIFO0_STAT : REG_DMA_FIFO1_STAT),
			.CTRL_ADDR(i == 0 ? REG_DMA_FIFO0_CTRL : REG_DMA_FIFO1_CTRL)
		) u_watch (
			.clk_i(clk_i),
			.reset_i(reset_i),
			.wr_en_i(wr_en),
			.reg_idx_i(reg_idx),
			.wdata_i(wdata),
			.be_i(be),
			.level_i(dma_fifo_cnt_i[i]),
			.rdata_o(dma_rdata[i]),
			.int_o(dma_fifo_full_int_o[i])
		);
	end

	for (genvar i = 0; i < NUM_RD_FIFO; i++) begin : g_rd_fifo
		fifo_watch #(
			.KIND(FIFO_DRAIN),
			.MARK(RD_EMPTY_MARK),
			.LIMIT(RD_LIMIT),
			.STATUS_ADDR(i == 0 ? REG_RD_FIFO0_STAT : REG_RD_FIFO1_STAT),
			.CTRL_ADDR(i == 0 ? REG_RD_FIFO0_CTRL : REG_RD_FIFO1_CTRL)
		) u_watch (
			.clk_i(clk_i),
			.reset_i(reset_i),
			.wr_en_i(wr_en),
			.reg_idx_i(reg_idx),
			.wdata_i(wdata),
			.be_i(be),
			.level_i(rd_fifo_length_i[i]),
			.rdata_o(rd_rdata[i]),
			.int_o(rd_fifo_empty_int_o[i])
		);
	end

	// Unaddressed blocks return zero
	always_comb begin
		dat_o = ctrl_rdata;
		for (int i = 0; i < NUM_DMA_FIFO; i++)
			dat_o = dat_o | dma_rdata[i];
		for (int i = 0; i < NUM_RD_FIFO; i++)
			dat_o = dat_o | rd_rdata[i];
	end

endmodule

`default_nettype wire

//--- tb_wb_dma_regs_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wb_dma_regs_asserts (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic cyc_i,
	input wire logic stb_i,
	input wire logic ack_i,
	input wire logic err_i,
	input wire logic [dma_regs_pkg::NUM_DMA_FIFO-1:0] dma_int_i,
	input wire logic [dma_regs_pkg::NUM_RD_FIFO-1:0] rd_int_i
);

	int fail_cnt = 0;

	// Ack only for a request seen at the previous edge
	ack_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
		$rose(ack_i) |-> $past(cyc_i && stb_i))
	else begin
		$error("ack_o rose without a request in the previous cycle");
		fail_cnt++;
	end

	err_with_ack: assert property (@(posedge clk_i) disable iff (reset_i) err_i |-> ack_i)
	else begin
		$error("err_o high without ack_o");
		fail_cnt++;
	end

	no_int_after_reset: assert property (@(posedge clk_i)
		$fell(reset_i) |-> (dma_int_i == '0 && rd_int_i == '0))
	else begin
		$error("interrupt high right after reset");
		fail_cnt++;
	end

endmodule

bind wb_dma_regs_top tb_wb_dma_regs_asserts u_asserts (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.cyc_i(cyc_i),
	.stb_i(stb_i),
	.ack_i(ack_o),
	.err_i(err_o),
	.dma_int_i(dma_fifo_full_int_o),
	.rd_int_i(rd_fifo_empty_int_o)
);

`default_nettype wire

//--- tb_wb_dma_regs.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wb_dma_regs;

	import dma_regs_pkg::*;

	localparam int MAX_VEC = 64;

	typedef enum logic [3:0] {
		OP_WRITE = 4'h0,
		OP_READ = 4'h1,
		OP_BURST = 4'h2,
		OP_BAD_CTI = 4'h3,
		OP_SET_LEVEL = 4'h4,
		OP_SET_STATUS = 4'h5,
		OP_SET_BUSY = 4'h6,
		OP_END = 4'hF
	} vec_op_e;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [BUS_ADDR_W-1:0] adr;
	cti_e cti;
	sel_t sel;
	data_t dat_w;
	data_t dat_r;
	logic ack;
	logic err;
	logic dma_in_use;
	logic [15:0] ctrl;
	logic [15:0] watch_dog_cnt;
	data_t dmaadr;
	data_t dmalen;
	data_t transfer_size;
	logic transfer_size_valid;
	logic [7:0] stat;
	logic stat_valid;
	fifo_cnt_t dma_cnt [NUM_DMA_FIFO];
	logic [NUM_DMA_FIFO-1:0] dma_int;
	fifo_cnt_t rd_len [NUM_RD_FIFO];
	logic [NUM_RD_FIFO-1:0] rd_int;

	logic [83:0] vectors [0:MAX_VEC-1];
	int vec_count;
	int cycle_cnt = 0;
	int cycle_limit = 1000000;
	logic [31:0] lfsr_q;

	wb_dma_regs_top dut (
		.clk_i(clk),
		.reset_i(reset),
		.cyc_i(cyc),
		.stb_i(stb),
		.we_i(we),
		.adr_i(adr),
		.cti_i(cti),
		.sel_i(sel),
		.dat_i(dat_w),
		.dat_o(dat_r),
		.ack_o(ack),
		.err_o(err),
		.dma_in_use_i(dma_in_use),
		.ctrl_o(ctrl),
		.watch_dog_cnt_o(watch_dog_cnt),
		.dmaadr_o(dmaadr),
		.dmalen_o(dmalen),
		.transfer_size_i(transfer_size),
		.transfer_size_valid_i(transfer_size_valid),
		.stat_i(stat),
		.stat_valid_i(stat_valid),
		.dma_fifo_cnt_i(dma_cnt),
		.dma_fifo_full_int_o(dma_int),
		.rd_fifo_length_i(rd_len),
		.rd_fifo_empty_int_o(rd_int)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
			stop_with_failure("timeout: the run did not finish within the cycle limit");
	end

	// ******************************
	// Compare tasks
	// ******************************
	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input fifo_cnt_t got, input fifo_cnt_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	function automatic data_t apply_byte_lanes(input data_t old, input data_t wdata,
			input sel_t lanes);
		data_t mask;
		mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
		return (wdata & mask) | (old & ~mask);
	endfunction

	// Galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic random_word(output data_t word);
		word = '0;
		for (int b = 0; b < DATA_W; b++) begin
			word = {word[DATA_W-2:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	// ******************************
	// Bus access
	// ******************************
	// Starts on a falling edge, returns on the falling edge of the ack cycle
	task automatic bus_cycle(input logic write, input logic [11:0] addr, input sel_t lanes,
			input data_t wdata, input cti_e code, output data_t rdata, output logic got_err);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = {20'd0, addr};
		sel = lanes;
		dat_w = wdata;
		cti = code;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		rdata = dat_r;
		got_err = err;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		cti = CTI_CLASSIC;
	endtask

	task automatic write_reg(input logic [11:0] addr, input sel_t lanes, input data_t wdata);
		data_t rdata;
		logic e;
		bus_cycle(1'b1, addr, lanes, wdata, CTI_CLASSIC, rdata, e);
		check_bit("err_o", e, 1'b0);
	endtask

	task automatic read_reg(input logic [11:0] addr, output data_t rdata);
		logic e;
		bus_cycle(1'b0, addr, 4'hF, '0, CTI_CLASSIC, rdata, e);
		check_bit("err_o", e, 1'b0);
	endtask

	task automatic read_and_check(input logic [11:0] addr, input data_t exp);
		data_t rdata;
		read_reg(addr, rdata);
		check_data("dat_o", rdata, exp);
		case (addr[11:2])
			REG_CONTROL: check_data("ctrl_o/watch_dog_cnt_o", {ctrl, watch_dog_cnt}, exp);
			REG_DMA_ADDR: check_data("dmaadr_o", dmaadr, exp);
			REG_DMA_LEN: check_data("dmalen_o", dmalen, exp);
			default: ;
		endcase
	endtask

	task automatic burst_write(input logic [11:0] addr, input sel_t lanes, input int beats);
		data_t prior [8];
		data_t beat_data [8];
		data_t rdata;
		if (beats < 1 || beats > 8)
			stop_with_failure("burst length in the vector file is out of range");
		for (int j = 0; j < beats; j++)
			read_reg(addr + 12'(4 * j), prior[j]);
		for (int j = 0; j < beats; j++) begin
			random_word(beat_data[j]);
			cyc = 1'b1;
			stb = 1'b1;
			we = 1'b1;
			adr = {20'd0, addr + 12'(4 * j)};
			sel = lanes;
			dat_w = beat_data[j];
			cti = (j == beats - 1) ? CTI_END : CTI_INCR;
			@(negedge clk);
			check_bit("ack_o", ack, 1'b1);
			check_bit("err_o", err, 1'b0);
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		cti = CTI_CLASSIC;
		for (int j = 0; j < beats; j++) begin
			read_reg(addr + 12'(4 * j), rdata);
			check_data("dat_o", rdata, apply_byte_lanes(prior[j], beat_data[j], lanes));
		end
	endtask

	task automatic bad_cti_write(input logic [11:0] addr, input sel_t lanes, input data_t wdata);
		data_t rdata;
		logic e;
		bus_cycle(1'b1, addr, lanes, wdata, cti_e'(3'b011), rdata, e);
		check_bit("err_o", e, 1'b1);
	endtask

	// Indices 0 and 1 are DMA FIFOs, 2 and 3 read FIFOs
	task automatic set_level(input int idx, input fifo_cnt_t level, input logic exp_int);
		data_t rdata;
		logic flag;
		fifo_cnt_t count;
		logic [11:0] addr;
		if (idx < 0 || idx > 3)
			stop_with_failure("FIFO index in the vector file is out of range");
		if (idx < NUM_DMA_FIFO) begin
			dma_cnt[idx] = level;
			flag = level > DMA_FIFO_FULL_MARK;
			count = {2'b00, level[25:0]};
		end else begin
			rd_len[idx - NUM_DMA_FIFO] = level;
			flag = level < RD_FIFO_EMPTY_MARK;
			count = (level > RD_FIFO_LIMIT) ? '0 : RD_FIFO_LIMIT - level;
			count[27:26] = 2'b00;
		end
		@(negedge clk);
		if (idx < NUM_DMA_FIFO)
			check_bit("dma_fifo_full_int_o", dma_int[idx], exp_int);
		else
			check_bit("rd_fifo_empty_int_o", rd_int[idx - NUM_DMA_FIFO], exp_int);
		case (idx)
			0: addr = {REG_DMA_FIFO0_STAT, 2'b00};
			1: addr = {REG_DMA_FIFO1_STAT, 2'b00};
			2: addr = {REG_RD_FIFO0_STAT, 2'b00};
			default: addr = {REG_RD_FIFO1_STAT, 2'b00};
		endcase
		read_reg(addr, rdata);
		check_bit("status flag", rdata[31], flag);
		check_count("status count", fifo_cnt_t'(rdata[27:2]), count);
	endtask

	task automatic pulse_result(input int which, input data_t value);
		if (which == 0) begin
			transfer_size = value;
			transfer_size_valid = 1'b1;
		end else begin
			stat = value[7:0];
			stat_valid = 1'b1;
		end
		@(negedge clk);
		transfer_size_valid = 1'b0;
		stat_valid = 1'b0;
		// New data without valid must be ignored
		if (which == 0)
			transfer_size = ~value;
		else
			stat = ~value[7:0];
	endtask

	// ******************************
	// Main sequence
	// ******************************
	initial begin
		logic [83:0] v;
		vec_op_e op;
		logic [11:0] addr;
		sel_t lanes;
		data_t data;
		data_t exp;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		cti = CTI_CLASSIC;
		sel = '0;
		dat_w = '0;
		dma_in_use = 1'b0;
		transfer_size = '0;
		transfer_size_valid = 1'b0;
		stat = '0;
		stat_valid = 1'b0;
		for (int i = 0; i < NUM_DMA_FIFO; i++)
			dma_cnt[i] = '0;
		for (int i = 0; i < NUM_RD_FIFO; i++)
			rd_len[i] = '0;
		lfsr_q = 32'h2416;
		$readmemh("dma_regs_vectors.txt", vectors);
		vec_count = 0;
		while (vec_count < MAX_VEC && !$isunknown(vectors[vec_count])
				&& vectors[vec_count][83:80] != OP_END)
			vec_count++;
		if (vec_count == 0)
			stop_with_failure("no vectors were read from dma_regs_vectors.txt");
		cycle_limit = 10 * vec_count + 100;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		// Everything starts cleared
		check_bit("ack_o", ack, 1'b0);
		check_bit("err_o", err, 1'b0);
		check_data("dmaadr_o", dmaadr, '0);
		check_data("dmalen_o", dmalen, '0);
		check_data("ctrl_o/watch_dog_cnt_o", {ctrl, watch_dog_cnt}, '0);
		for (int i = 0; i < NUM_DMA_FIFO; i++)
			check_bit("dma_fifo_full_int_o", dma_int[i], 1'b0);
		for (int i = 0; i < NUM_RD_FIFO; i++)
			check_bit("rd_fifo_empty_int_o", rd_int[i], 1'b0);
		for (int n = 0; n < vec_count; n++) begin
			v = vectors[n];
			op = vec_op_e'(v[83:80]);
			addr = v[79:68];
			lanes = v[67:64];
			data = v[63:32];
			exp = v[31:0];
			case (op)
				OP_WRITE: write_reg(addr, lanes, data);
				OP_READ: read_and_check(addr, exp);
				OP_BURST: burst_write(addr, lanes, int'(data));
				OP_BAD_CTI: bad_cti_write(addr, lanes, data);
				OP_SET_LEVEL: set_level(int'(addr), data[FIFO_CNT_W-1:0], exp[0]);
				OP_SET_STATUS: pulse_result(int'(addr), data);
				OP_SET_BUSY: begin
					dma_in_use = data[0];
					@(negedge clk);
				end
				default: stop_with_failure("unknown operation code in the vector file");
			endcase
			if (dut.u_asserts.fail_cnt != 0)
				stop_with_failure("a bus or interrupt assertion failed");
		end
		@(negedge clk);
		if (dut.u_asserts.fail_cnt == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stop_with_failure("a bus or interrupt assertion failed");
		end
	end

endmodule

`default_nettype wire

//--- dma_regs_vectors.txt
// op_addr_sel_data_expected, op 0 write 1 read 2 burst 3 bad-cti 4 set-level 5 set-status
// 6 set-busy F end; burst data is the beat count, set-level addr is the FIFO index
0_008_F_12345678_00000000
0_008_2_AABBCCDD_00000000
1_008_0_00000000_1234CC78
0_00C_5_11223344_00000000
1_00C_0_00000000_00220044
0_004_C_DEAD0000_00000000
0_004_1_000000EF_00000000
1_004_0_00000000_DEAD00EF
// Busy DMA keeps address and length
6_000_0_00000001_00000000
0_008_F_FFFFFFFF_00000000
0_00C_F_FFFFFFFF_00000000
0_004_F_0000FFFF_00000000
1_008_0_00000000_1234CC78
1_00C_0_00000000_00220044
1_004_0_00000000_5EAD00EF
0_004_7_FFFFFFFF_00000000
1_004_0_00000000_5EAD00EF
6_000_0_00000000_00000000
// Bursts and a bad cycle type
2_004_F_00000003_00000000
2_008_6_00000002_00000000
0_008_F_CAFEF00D_00000000
3_008_F_00000000_00000000
1_008_0_00000000_CAFEF00D
5_000_0_0000BEEF_00000000
5_001_0_000000A5_00000000
1_010_0_00000000_0000BEEF
1_014_0_00000000_000000A5
6_000_0_00000001_00000000
1_014_0_00000000_000080A5
6_000_0_00000000_00000000
// FIFO watchers
4_000_0_00000FF4_00000000
1_018_0_00000000_80003FD0
0_01C_8_80000000_00000000
4_000_0_00000FF4_00000001
4_000_0_00000FF3_00000000
4_001_0_00001000_00000000
1_040_0_00000000_80004000
4_002_0_00000064_00000000
1_020_0_00000000_00001E50
0_024_8_80000000_00000000
4_002_0_00000000_00000001
1_020_0_00000000_80001FE0
4_003_0_00000800_00000000
1_028_0_00000000_00000000
F_000_0_00000000_00000000

//--- verilog.f
dma_regs_pkg.sv
wb_cycle_decoder.sv
dma_ctrl_regs.sv
fifo_watch.sv
wb_dma_regs_top.sv
tb_wb_dma_regs_asserts.sv
tb_wb_dma_regs.sv
